// File: radio_ctrl.f
radio_ctrl_pkg.sv
settings_port.sv
misc_regs.sv
vita_timer.sv
readback_port.sv
radio_ctrl_top.sv
tb_radio_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the radio control plane testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_radio_ctrl
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module "$TOP" -f radio_ctrl.f -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if ! grep -q "All tests passed!" "$LOG"; then
   echo "Simulation ended without a pass report"
   exit 1
fi

echo "Simulation PASSED"
exit 0

// File: tb_radio_ctrl.sv
/*
 * Directed testbench for the radio control plane
 *  - clock, reset and run timeout
 *  - settings write and readback handshake tasks
 *  - reset, control register, LED, timer, PPS and readback tests
 */
`timescale 1ns/1ps

module tb_radio_ctrl
   import radio_ctrl_pkg::*;
;

   // Whole run is roughly 250 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic                dsp_clk;
   logic                por_rst;
   logic                set_req_i;
   set_word_t           set_word_i;
   logic                set_ack_o;
   logic                rb_req_i;
   logic [RB_IDX_W-1:0] rb_idx_i;
   logic                rb_ack_o;
   logic [31:0]         rb_data_o;
   radio_status_t       status_i;
   logic                pps_i;
   ctrl_lines_t         ctrl_o;
   logic [7:0]          leds_o;
   int                  cycle_count;

   radio_ctrl_top UUT (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .set_req_i (set_req_i),
      .set_word_i(set_word_i),
      .set_ack_o (set_ack_o),
      .rb_req_i  (rb_req_i),
      .rb_idx_i  (rb_idx_i),
      .rb_ack_o  (rb_ack_o),
      .rb_data_o (rb_data_o),
      .status_i  (status_i),
      .pps_i     (pps_i),
      .ctrl_o    (ctrl_o),
      .leds_o    (leds_o)
   );

   always #5 dsp_clk = ~dsp_clk;

   ////////////////////
   // Failure reporting
   task automatic stop_on_failure();
      $display("Test failures found");
      $fatal(1, "Simulation stopped at the first failed check");
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("ERROR: %s", what);
         stop_on_failure();
      end
   endtask

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_on_failure();
      end
   end

   ////////////////////
   // Handshakes
   task automatic write_setting(input logic [SET_ADDR_W-1:0] addr,
                                input logic [SET_DATA_W-1:0] data);
      set_word_t word;
      word.addr = addr;
      word.data = data;
      @(posedge dsp_clk);
      set_word_i <= word;
      set_req_i  <= 1'b1;
      @(negedge dsp_clk);
      while (!set_ack_o) @(negedge dsp_clk);
      @(posedge dsp_clk);
      set_req_i <= 1'b0;
      @(negedge dsp_clk);
      while (set_ack_o) @(negedge dsp_clk);
   endtask

   task automatic read_word(input logic [RB_IDX_W-1:0] idx, output logic [31:0] data);
      @(posedge dsp_clk);
      rb_idx_i <= idx;
      rb_req_i <= 1'b1;
      @(negedge dsp_clk);
      while (!rb_ack_o) @(negedge dsp_clk);
      data = rb_data_o;
      @(posedge dsp_clk);
      rb_req_i <= 1'b0;
      @(negedge dsp_clk);
      while (rb_ack_o) @(negedge dsp_clk);
   endtask

   task automatic drive_random_status();
      logic [31:0] rnd;
      rnd = $urandom;
      @(posedge dsp_clk);
      status_i <= rnd[5:0];
      @(negedge dsp_clk);
   endtask

   ////////////////////
   // Expected values
   function automatic ctrl_lines_t expected_ctrl(input logic [31:0] clk_w, input logic [31:0] ser_w,
                                                 input logic [31:0] adc_w, input logic [31:0] phy_w);
      ctrl_lines_t c;
      c             = '0;
      c.clock_ready = clk_w[4];
      c.clk_en      = clk_w[3:2];
      c.clk_sel     = clk_w[1:0];
      c.ser_enable  = ser_w[3];
      c.ser_prbsen  = ser_w[2];
      c.ser_loopen  = ser_w[1];
      c.ser_rx_en   = ser_w[0];
      c.adc_oe_a    = adc_w[3];
      c.adc_on_a    = adc_w[2];
      c.adc_oe_b    = adc_w[1];
      c.adc_on_b    = adc_w[0];
      c.phy_reset_n = ~phy_w[0];
      return c;
   endfunction

   function automatic logic [7:0] expected_leds(input logic [7:0] mask, input logic [7:0] sw,
                                                input radio_status_t st);
      logic [7:0] hw;
      hw    = 8'h00;
      hw[4] = st.run_tx;
      hw[3] = st.run_rx;
      hw[2] = st.clk_status;
      hw[1] = st.serdes_link_up & st.good_sync;
      return (mask & hw) | (~mask & sw);
   endfunction

   function automatic logic [31:0] expected_status(input radio_status_t st);
      logic [31:0] w;
      w     = 32'h0;
      w[13] = st.button;
      w[11] = st.clk_status;
      w[10] = st.serdes_link_up;
      return w;
   endfunction

   ////////////////////
   // Tests
   task automatic test_reset_state();
      ctrl_lines_t exp_ctrl;
      logic [31:0] rd;
      // Reset register is clear and the line is its inverse
      exp_ctrl = expected_ctrl(32'h0, 32'h0, 32'h0, 32'h0);
      @(negedge dsp_clk);
      check_value("reset set_ack", 32'h0, 32'(set_ack_o));
      check_value("reset rb_ack", 32'h0, 32'(rb_ack_o));
      check_value("reset ctrl", 32'(exp_ctrl), 32'(ctrl_o));
      read_word(RB_COMPAT, rd);
      check_value("reset compat", 32'h000A0001, rd);
   endtask

   task automatic test_ctrl_regs();
      logic [31:0] d[5];
      ctrl_lines_t exp_ctrl;
      for (int n = 0; n < 4; n++) begin
         for (int k = 0; k < 5; k++) begin
            d[k] = $urandom;
         end
         write_setting(SR_MISC + 8'd0, d[0]);
         write_setting(SR_MISC + 8'd1, d[1]);
         write_setting(SR_MISC + 8'd2, d[2]);
         write_setting(SR_MISC + 8'd4, d[4]);
         exp_ctrl = expected_ctrl(d[0], d[1], d[2], d[4]);
         check_value("ctrl lines", 32'(exp_ctrl), 32'(ctrl_o));
         check_value("phy_reset_n", {31'd0, ~d[4][0]}, {31'd0, ctrl_o.phy_reset_n});
      end
   endtask

   task automatic test_led_mux();
      logic [7:0]  mask;
      logic [7:0]  sw;
      logic [31:0] rnd;
      logic [31:0] rd;
      mask = 8'h1E;
      for (int n = 0; n < 6; n++) begin
         // Second half runs with a random source mask
         if (n == 3) begin
            rnd  = $urandom;
            mask = rnd[7:0];
            write_setting(SR_MISC + 8'd6, rnd);
         end
         rnd = $urandom;
         sw  = rnd[7:0];
         write_setting(SR_MISC + 8'd3, rnd);
         drive_random_status();
         check_value("led mux", 32'(expected_leds(mask, sw, status_i)), 32'(leds_o));
         read_word(RB_LEDS, rd);
         check_value("led readback", 32'(expected_leds(mask, sw, status_i)), rd);
      end
   endtask

   task automatic load_time(output logic [63:0] loaded);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $urandom;
      lo = $urandom_range(255, 0);
      write_setting(SR_TIME64, hi);
      write_setting(SR_TIME64 + 8'd1, lo);
      loaded = {hi, lo};
   endtask

   task automatic test_timer_load();
      logic [63:0] loaded;
      logic [31:0] rd_hi;
      logic [31:0] lo_a;
      logic [31:0] lo_b;
      load_time(loaded);
      read_word(RB_TIME_HI, rd_hi);
      check_value("time high word", loaded[63:32], rd_hi);
      read_word(RB_TIME_LO, lo_a);
      read_word(RB_TIME_LO, lo_b);
      check_true(lo_a > loaded[31:0], "first low-word read is not past the loaded value");
      check_true(lo_b > lo_a, "second low-word read did not advance past the first");
   endtask

   task automatic test_pps_latch();
      logic [63:0] loaded;
      logic [63:0] pps_time;
      logic [63:0] now_time;
      load_time(loaded);
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      @(posedge dsp_clk);
      pps_i <= 1'b0;
      // Count is latched two edges after the pulse arrives
      repeat (3) @(posedge dsp_clk);
      read_word(RB_PPS_HI, pps_time[63:32]);
      read_word(RB_PPS_LO, pps_time[31:0]);
      read_word(RB_TIME_HI, now_time[63:32]);
      read_word(RB_TIME_LO, now_time[31:0]);
      check_true(pps_time >= loaded, "PPS time is earlier than the loaded time");
      check_true(pps_time <= now_time, "PPS time is later than the current time");
   endtask

   task automatic test_readback();
      logic [31:0] rd;
      for (int i = 7; i < 16; i++) begin
         read_word(RB_IDX_W'(i), rd);
         check_value("unused index", 32'hFFFFFFFF, rd);
      end
      for (int n = 0; n < 6; n++) begin
         drive_random_status();
         read_word(RB_STATUS, rd);
         check_value("status word", expected_status(status_i), rd);
      end
   endtask

   ////////////////////
   // Main sequence
   initial begin
      dsp_clk     = 1'b0;
      por_rst     = 1'b1;
      set_req_i   = 1'b0;
      set_word_i  = '0;
      rb_req_i    = 1'b0;
      rb_idx_i    = '0;
      status_i    = '0;
      pps_i       = 1'b0;
      cycle_count = 0;
      void'($urandom(32'he56));
      repeat (2) @(posedge dsp_clk);
      por_rst <= 1'b0;

      test_reset_state();
      test_ctrl_regs();
      test_led_mux();
      test_timer_load();
      test_pps_latch();
      test_readback();

      $display("All tests passed!");
      $finish;
   end

endmodule

// File: radio_ctrl_top.sv
/*
 * Radio control plane top level
 * Settings write port, misc registers, VITA timer
 * and readback port on one clock
 */
`timescale 1ns/1ps

module radio_ctrl_top
   import radio_ctrl_pkg::*;
#(
   parameter logic [31:0] COMPAT_NUM    = {16'd10, 16'd1},
   parameter logic [7:0]  LED_SRC_RESET = 8'h1E
) (
   input  logic                dsp_clk,
   input  logic                por_rst,
   // Settings write handshake
   input  logic                set_req_i,
   input  set_word_t           set_word_i,
   output logic                set_ack_o,
   // Readback handshake
   input  logic                rb_req_i,
   input  logic [RB_IDX_W-1:0] rb_idx_i,
   output logic                rb_ack_o,
   output logic [31:0]         rb_data_o,
   // Board side
   input  radio_status_t       status_i,
   input  logic                pps_i,
   output ctrl_lines_t         ctrl_o,
   output logic [7:0]          leds_o
);

   logic        set_stb;
   set_word_t   set_word;
   logic [7:0]  led_state;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   settings_port u_settings_port (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_req_i  (set_req_i),
      .set_word_i (set_word_i),
      .set_ack_o  (set_ack_o),
      .set_stb_o  (set_stb),
      .set_word_o (set_word)
   );

   misc_regs #(.LED_SRC_RESET(LED_SRC_RESET)) u_misc_regs (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_stb_i   (set_stb),
      .set_word_i  (set_word),
      .status_i    (status_i),
      .ctrl_o      (ctrl_o),
      .leds_o      (leds_o),
      .led_state_o (led_state)
   );

   vita_timer u_vita_timer (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_stb_i       (set_stb),
      .set_word_i      (set_word),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   readback_port #(.COMPAT_NUM(COMPAT_NUM)) u_readback_port (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_req_i        (rb_req_i),
      .rb_idx_i        (rb_idx_i),
      .status_i        (status_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .led_state_i     (led_state),
      .rb_ack_o        (rb_ack_o),
      .rb_data_o       (rb_data_o)
   );

endmodule

// File: readback_port.sv
/*
 * Readback port
 * Four-phase req/ack read handshake and the readback word mux
 * for compat number, status, time, PPS time and LED state
 */
`timescale 1ns/1ps

module readback_port
   import radio_ctrl_pkg::*;
#(
   parameter logic [31:0] COMPAT_NUM = {16'd10, 16'd1}
) (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  logic                rb_req_i,
   input  logic [RB_IDX_W-1:0] rb_idx_i,
   input  radio_status_t       status_i,
   input  logic [63:0]         vita_time_i,
   input  logic [63:0]         vita_time_pps_i,
   input  logic [7:0]          led_state_i,
   output logic                rb_ack_o,
   output logic [31:0]         rb_data_o
);

   typedef enum logic {
      S_IDLE,
      S_ACK
   } state_t;

   state_t      state;
   logic [31:0] status_word;
   logic [31:0] mux_word;
   logic [31:0] data_q;

   // Same bit positions as the legacy status word
   assign status_word = {18'd0, status_i.button, 1'b0, status_i.clk_status,
                         status_i.serdes_link_up, 10'd0};

   ////////////////////
   // Word mux
   always_comb begin
      case (rb_idx_i)
         RB_COMPAT:  mux_word = COMPAT_NUM;
         RB_STATUS:  mux_word = status_word;
         RB_TIME_HI: mux_word = vita_time_i[63:32];
         RB_TIME_LO: mux_word = vita_time_i[31:0];
         RB_PPS_HI:  mux_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  mux_word = vita_time_pps_i[31:0];
         RB_LEDS:    mux_word = {24'd0, led_state_i};
         default:    mux_word = '1;
      endcase
   end

   ////////////////////
   // Read handshake
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state <= S_IDLE;
      end else if (state == S_IDLE) begin
         if (rb_req_i) begin
            state <= S_ACK;
         end
      end else if (!rb_req_i) begin
         state <= S_IDLE;
      end
   end

   // Data sampled once per transfer, held through ack
   always_ff @(posedge dsp_clk) begin
      if (state == S_IDLE && rb_req_i) begin
         data_q <= mux_word;
      end
   end

   assign rb_ack_o  = (state == S_ACK);
   assign rb_data_o = data_q;

   a_data_held: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rb_ack_o && $past(rb_ack_o) |-> $stable(rb_data_o));

endmodule

// File: vita_timer.sv
/*
 * 64-bit VITA time counter
 * Free running, loaded from two settings words,
 * with a PPS edge detector that latches the count
 */
`timescale 1ns/1ps

module vita_timer
   import radio_ctrl_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        set_stb_i,
   input  set_word_t   set_word_i,
   input  logic        pps_i,
   output logic [63:0] vita_time_o,
   output logic [63:0] vita_time_pps_o
);

   logic [31:0] time_hi_stage;
   logic        load_hi;
   logic        load_lo;
   logic        pps_q;
   logic        pps_q_d;
   logic        pps_edge;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   assign load_hi = set_stb_i && (set_word_i.addr == SR_TIME64);
   assign load_lo = set_stb_i && (set_word_i.addr == SR_TIME64 + 8'd1);

   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (load_hi) begin
         time_hi_stage <= set_word_i.data;
      end
   end

   ////////////////////
   // Counter
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time <= '0;
      end else if (load_lo) begin
         vita_time <= {time_hi_stage, set_word_i.data};
      end else begin
         vita_time <= vita_time + 64'd1;
      end
   end

   ////////////////////
   // PPS capture
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_q         <= 1'b0;
         pps_q_d       <= 1'b0;
         vita_time_pps <= '0;
      end else begin
         pps_q   <= pps_i;
         pps_q_d <= pps_q;
         if (pps_edge) begin
            vita_time_pps <= vita_time;
         end
      end
   end

   assign pps_edge        = pps_q & ~pps_q_d;
   assign vita_time_o     = vita_time;
   assign vita_time_pps_o = vita_time_pps;

   // Time only jumps on a low-word load
   a_time_advances: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !$past(load_lo) && !$past(por_rst) |-> vita_time_o == $past(vita_time_o) + 64'd1);

endmodule

// File: misc_regs.sv
/*
 * Miscellaneous setting registers
 * Clock generator, serializer, ADC and PHY control lines,
 * software LED word, LED source mask and the LED mux
 */
`timescale 1ns/1ps

module misc_regs
   import radio_ctrl_pkg::*;
#(
   parameter logic [7:0] LED_SRC_RESET = 8'h1E
) (
   input  logic          dsp_clk,
   input  logic          por_rst,
   input  logic          set_stb_i,
   input  set_word_t     set_word_i,
   input  radio_status_t status_i,
   output ctrl_lines_t   ctrl_o,
   output logic [7:0]    leds_o,
   output logic [7:0]    led_state_o
);

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reset;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic [7:0] led_word;

   ////////////////////
   // Register bank
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         led_sw    <= '0;
         phy_reset <= 1'b0;
         led_src   <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_word_i.addr)
            SR_MISC + 8'd0: clk_reg   <= set_word_i.data[4:0];
            SR_MISC + 8'd1: ser_reg   <= set_word_i.data[3:0];
            SR_MISC + 8'd2: adc_reg   <= set_word_i.data[3:0];
            SR_MISC + 8'd3: led_sw    <= set_word_i.data[7:0];
            SR_MISC + 8'd4: phy_reset <= set_word_i.data[0];
            SR_MISC + 8'd6: led_src   <= set_word_i.data[7:0];
            default: ;
         endcase
      end
   end

   ////////////////////
   // Control line mapping
   always_comb begin
      ctrl_o             = '0;
      ctrl_o.clock_ready = clk_reg[4];
      ctrl_o.clk_en      = clk_reg[3:2];
      ctrl_o.clk_sel     = clk_reg[1:0];
      ctrl_o.ser_enable  = ser_reg[3];
      ctrl_o.ser_prbsen  = ser_reg[2];
      ctrl_o.ser_loopen  = ser_reg[1];
      ctrl_o.ser_rx_en   = ser_reg[0];
      ctrl_o.adc_oe_a    = adc_reg[3];
      ctrl_o.adc_on_a    = adc_reg[2];
      ctrl_o.adc_oe_b    = adc_reg[1];
      ctrl_o.adc_on_b    = adc_reg[0];
      // PHY held in reset while the register bit is set
      ctrl_o.phy_reset_n = ~phy_reset;
   end

   ////////////////////
   // LEDs, mask bit 1 selects hardware
   assign led_hw = {3'b000, status_i.run_tx, status_i.run_rx, status_i.clk_status,
                    status_i.serdes_link_up & status_i.good_sync, 1'b0};

   assign led_word    = (led_src & led_hw) | (~led_src & led_sw);
   assign leds_o      = led_word;
   assign led_state_o = led_word;

endmodule

// File: settings_port.sv
/*
 * Settings write port
 * Four-phase req/ack handshake from the host, turned into a
 * single-cycle settings strobe with captured address and data
 */
`timescale 1ns/1ps

module settings_port
   import radio_ctrl_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_req_i,
   input  set_word_t set_word_i,
   output logic      set_ack_o,
   output logic      set_stb_o,
   output set_word_t set_word_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_ACKED,
      S_RELEASE
   } state_t;

   state_t    state;
   set_word_t word_q;

   ////////////////////
   // Handshake FSM
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (set_req_i) begin
                  state <= S_ACKED;
               end
            end
            // Strobe cycle, req may already be gone
            S_ACKED: begin
               state <= set_req_i ? S_RELEASE : S_IDLE;
            end
            S_RELEASE: begin
               if (!set_req_i) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Host holds the word stable until ack falls
   always_ff @(posedge dsp_clk) begin
      if (state == S_IDLE && set_req_i) begin
         word_q <= set_word_i;
      end
   end

   assign set_ack_o  = (state != S_IDLE);
   assign set_stb_o  = (state == S_ACKED);
   assign set_word_o = word_q;

   ////////////////////
   // Protocol checks
   a_ack_needs_req: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(set_ack_o) |-> $past(set_req_i));

   a_single_strobe: assert property (@(posedge dsp_clk) disable iff (por_rst)
      set_stb_o |=> !set_stb_o);

endmodule

// File: radio_ctrl_pkg.sv
/*
 * Shared definitions for the radio control plane
 *  - settings bus and readback widths
 *  - settings register addresses and readback word indices
 *  - settings word, control line and status structs
 */
package radio_ctrl_pkg;

   ////////////////////
   // Bus widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_IDX_W   = 4;

   ////////////////////
   // Settings register bases
   // Misc block: +0 clock, +1 serializer, +2 ADC, +3 software LEDs,
   // +4 PHY reset, +6 LED source
   localparam logic [SET_ADDR_W-1:0] SR_MISC   = 8'd0;
   // Timer block: +0 staged high word, +1 low word and load
   localparam logic [SET_ADDR_W-1:0] SR_TIME64 = 8'd10;

   ////////////////////
   // Readback word indices, anything else reads all ones
   localparam logic [RB_IDX_W-1:0] RB_COMPAT  = 4'd0;
   localparam logic [RB_IDX_W-1:0] RB_STATUS  = 4'd1;
   localparam logic [RB_IDX_W-1:0] RB_TIME_HI = 4'd2;
   localparam logic [RB_IDX_W-1:0] RB_TIME_LO = 4'd3;
   localparam logic [RB_IDX_W-1:0] RB_PPS_HI  = 4'd4;
   localparam logic [RB_IDX_W-1:0] RB_PPS_LO  = 4'd5;
   localparam logic [RB_IDX_W-1:0] RB_LEDS    = 4'd6;

   // One settings bus transfer
   typedef struct packed {
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_word_t;

   // Board control lines, clock generator down to PHY
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
      logic [1:0] spare;
   } ctrl_lines_t;

   // Status bits from the rest of the radio
   typedef struct packed {
      logic clk_status;
      logic serdes_link_up;
      logic good_sync;
      logic run_rx;
      logic run_tx;
      logic button;
   } radio_status_t;

endpackage
